// ==== src.f ====
+incdir+sim
source/tinker_pkg.sv
source/fetch_unit.sv
source/register_file.sv
source/execute_unit.sv
source/unified_memory.sv
source/tinker_core.sv
sim/tinker_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tinker_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' src.f)
HDRS := sim/tinker_model.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): src.f $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f src.f --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tinker_model.svh ====
`ifndef TINKER_MODEL_SVH
`define TINKER_MODEL_SVH

logic [7:0]  model_mem [65536];
logic [63:0] model_regs [32];
logic [31:0] prog [$];

function automatic int rnd(input int n);
    return int'($unsigned($random(seed)) % n);
endfunction

function automatic logic [31:0] enc(input tinker_pkg::op_t op, input int rd, input int rs,
                                    input int rt, input logic [11:0] lit);
    return {op, 5'(rd), 5'(rs), 5'(rt), lit};
endfunction

function automatic logic [63:0] mread(input logic [15:0] addr, input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
        v[8*i +: 8] = model_mem[addr + 16'(i)];
    return v;
endfunction

task automatic mwrite(input logic [15:0] addr, input logic [63:0] v, input int n);
    for (int i = 0; i < n; i++)
        model_mem[addr + 16'(i)] = v[8*i +: 8];
endtask

// one random register or immediate operation on r1..r8
task automatic emit_alu();
    tinker_pkg::op_t ops [15];
    tinker_pkg::op_t op;
    logic [11:0]     lit;
    ops = '{tinker_pkg::op_add, tinker_pkg::op_addi, tinker_pkg::op_sub, tinker_pkg::op_subi,
            tinker_pkg::op_mul, tinker_pkg::op_and, tinker_pkg::op_or, tinker_pkg::op_xor,
            tinker_pkg::op_not, tinker_pkg::op_shftr, tinker_pkg::op_shftri,
            tinker_pkg::op_shftl, tinker_pkg::op_shftli, tinker_pkg::op_mov,
            tinker_pkg::op_movl};
    op  = ops[rnd(15)];
    lit = 12'(rnd(4096));
    if (op == tinker_pkg::op_shftri || op == tinker_pkg::op_shftli)
        lit = 12'(rnd(64));
    prog.push_back(enc(op, 1 + rnd(8), 1 + rnd(8), 1 + rnd(8), lit));
endtask

task automatic gen_program(input int body_len);
    int          skip;
    int          kind;
    logic [15:0] tgt;
    logic [11:0] off;
    prog.delete();
    prog.push_back(enc(tinker_pkg::op_movl, 9, 0, 0, 12'h001));    // r9 = 0x8000 data window
    prog.push_back(enc(tinker_pkg::op_shftli, 9, 0, 0, 12'd15));
    prog.push_back(enc(tinker_pkg::op_movl, 10, 0, 0, 12'h001));   // r10 = 0x2000 branch base
    prog.push_back(enc(tinker_pkg::op_shftli, 10, 0, 0, 12'd13));
    prog.push_back(enc(tinker_pkg::op_movl, 11, 0, 0, 12'h009));   // r11 = 0x9000 results
    prog.push_back(enc(tinker_pkg::op_shftli, 11, 0, 0, 12'd12));
    for (int k = 1; k <= 8; k++)
        prog.push_back(enc(tinker_pkg::op_load, k, 9, 0, 12'(8 * k)));
    while (prog.size() < body_len) begin
        kind = rnd(20);
        if (kind < 14) begin
            emit_alu();
        end else if (kind < 16) begin
            prog.push_back(enc(tinker_pkg::op_load, 1 + rnd(8), 9, 0, 12'(8 * rnd(32))));
        end else if (kind < 18) begin
            off = 12'(8 * rnd(32));
            prog.push_back(enc(tinker_pkg::op_store, 9, 1 + rnd(8), 0, off));
            if (kind == 17)     // read straight back
                prog.push_back(enc(tinker_pkg::op_load, 1 + rnd(8), 9, 0, off));
        end else begin
            skip = 1 + rnd(3);
            kind = rnd(3);
            if (kind == 0) begin
                prog.push_back(enc(tinker_pkg::op_br, 0, 0, 0, 12'(4 * (skip + 1))));
            end else begin
                tgt = 16'h2000 + 16'(4 * (prog.size() + 2 + skip));
                prog.push_back(enc(tinker_pkg::op_movl, 10, 0, 0, tgt[11:0]));
                if (kind == 1)
                    prog.push_back(enc(tinker_pkg::op_brnz, 10, 1 + rnd(8), 0, 12'h0));
                else
                    prog.push_back(enc(tinker_pkg::op_brgt, 10, 1 + rnd(8), 1 + rnd(8), 12'h0));
            end
            for (int k = 0; k < skip; k++)
                emit_alu();
        end
    end
    for (int k = 1; k <= 8; k++)
        prog.push_back(enc(tinker_pkg::op_store, 11, k, 0, 12'(8 * (k - 1))));
    prog.push_back(enc(tinker_pkg::op_halt, 0, 0, 0, 12'h0));
endtask

// interprets the words in model_mem from the reset pc up to halt
task automatic run_model();
    logic [63:0] pc;
    logic [63:0] nxt;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] d;
    logic [63:0] lit;
    logic [31:0] w;
    logic [4:0]  op;
    logic [4:0]  rd;
    for (int i = 0; i < 32; i++)
        model_regs[i] = '0;
    model_regs[31] = 64'd65536;
    pc = 64'h2000;
    for (int steps = 0; steps < 10000; steps++) begin
        w   = 32'(mread(16'(pc), 4));
        op  = w[31:27];
        rd  = w[26:22];
        lit = {{52{w[11]}}, w[11:0]};
        a   = model_regs[w[21:17]];
        b   = model_regs[w[16:12]];
        d   = model_regs[rd];
        nxt = pc + 64'd4;
        case (op)
            tinker_pkg::op_add:    model_regs[rd] = a + b;
            tinker_pkg::op_addi:   model_regs[rd] = d + lit;
            tinker_pkg::op_sub:    model_regs[rd] = a - b;
            tinker_pkg::op_subi:   model_regs[rd] = d - lit;
            tinker_pkg::op_mul:    model_regs[rd] = a * b;
            tinker_pkg::op_and:    model_regs[rd] = a & b;
            tinker_pkg::op_or:     model_regs[rd] = a | b;
            tinker_pkg::op_xor:    model_regs[rd] = a ^ b;
            tinker_pkg::op_not:    model_regs[rd] = ~a;
            tinker_pkg::op_shftr:  model_regs[rd] = a >> b;
            tinker_pkg::op_shftri: model_regs[rd] = d >> lit;
            tinker_pkg::op_shftl:  model_regs[rd] = a << b;
            tinker_pkg::op_shftli: model_regs[rd] = d << lit;
            tinker_pkg::op_mov:    model_regs[rd] = a;
            tinker_pkg::op_movl:   model_regs[rd] = {d[63:12], w[11:0]};
            tinker_pkg::op_load:   model_regs[rd] = mread(16'(a + lit), 8);
            tinker_pkg::op_store:  mwrite(16'(d + lit), a, 8);
            tinker_pkg::op_br:     nxt = pc + lit;
            tinker_pkg::op_brnz:   if (a != '0) nxt = d;
            tinker_pkg::op_brgt:   if ($signed(a) > $signed(b)) nxt = d;
            tinker_pkg::op_halt:   return;
            default: ;
        endcase
        pc = nxt;
    end
endtask

`endif

// ==== sim/tinker_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tinker_tb;

    localparam int n_progs   = 12;
    localparam int max_words = 80;
    localparam int body_len  = 48;
    // each program gets max_words * 20 cycles, plus window setup and the halt-only run
    localparam longint watchdog_ns = longint'(n_progs + 2) * max_words * 20 * 20;

    logic                 clk;
    logic                 reset;
    logic                 run;
    logic                 hlt;
    tinker_pkg::apb_req_t apb;
    tinker_pkg::apb_rsp_t apb_out;
    integer               seed;
    int                   errors;
    logic [31:0]          rdata;
    logic [31:0]          wval;
    logic                 err;

    `include "tinker_model.svh"

    tinker_core dut0 (
        .clk(clk), .reset(reset), .run(run), .apb(apb), .apb_out(apb_out), .hlt(hlt)
    );

    always #10 clk = ~clk;

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rd_data, output logic slverr);
        @(posedge clk);
        apb <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb.penable <= 1'b1;
        @(negedge clk);
        rd_data = apb_out.prdata;
        slverr  = apb_out.pslverr;
        check("pready", 64'(apb_out.pready), 64'h1);    // zero wait states
        @(posedge clk);
        apb <= '0;
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check("hlt", 64'(hlt), 64'h0);
    endtask

    // writes prog at the reset pc, then reads every word back
    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            apb_xfer(1'b1, 16'h2000 + 16'(4 * i), prog[i], rdata, err);
            check("pslverr", 64'(err), 64'h0);
            mwrite(16'h2000 + 16'(4 * i), 64'(prog[i]), 4);
        end
        for (int i = 0; i < prog.size(); i++) begin
            apb_xfer(1'b0, 16'h2000 + 16'(4 * i), 32'h0, rdata, err);
            check("prdata", 64'(rdata), 64'(prog[i]));
            check("pslverr", 64'(err), 64'h0);
        end
    endtask

    task automatic run_to_halt(input logic poke_while_busy);
        @(posedge clk);
        run <= 1'b1;
        if (poke_while_busy) begin
            apb_xfer(1'b1, 16'h8000, 32'hdead_beef, rdata, err);  // must be dropped
            check("pslverr", 64'(err), 64'h1);
        end
        @(negedge clk);
        while (!hlt)
            @(negedge clk);
        @(posedge clk);
        run <= 1'b0;
    endtask

    task automatic compare_memory();
        for (int i = 0; i < 16; i++) begin
            apb_xfer(1'b0, 16'h9000 + 16'(4 * i), 32'h0, rdata, err);
            check("result", 64'(rdata), mread(16'h9000 + 16'(4 * i), 4));
            check("pslverr", 64'(err), 64'h0);
        end
        for (int i = 0; i < 64; i++) begin
            apb_xfer(1'b0, 16'h8000 + 16'(4 * i), 32'h0, rdata, err);
            check("window", 64'(rdata), mread(16'h8000 + 16'(4 * i), 4));
            check("pslverr", 64'(err), 64'h0);
        end
    endtask

    initial begin
        clk    = 1'b0;
        reset  = 1'b1;
        run    = 1'b0;
        apb    = '0;
        seed   = 43;
        errors = 0;
        pulse_reset();

        // data window gets random contents
        for (int i = 0; i < 64; i++) begin
            wval = $random(seed);
            apb_xfer(1'b1, 16'h8000 + 16'(4 * i), wval, rdata, err);
            check("pslverr", 64'(err), 64'h0);
            mwrite(16'h8000 + 16'(4 * i), 64'(wval), 4);
        end

        // halt on its own
        prog.delete();
        prog.push_back(enc(tinker_pkg::op_halt, 0, 0, 0, 12'h0));
        load_program();
        run_to_halt(1'b0);

        for (int p = 0; p < n_progs; p++) begin
            pulse_reset();
            gen_program(body_len);
            load_program();
            run_model();
            run_to_halt(1'b1);
            compare_memory();
        end

        $display("run finished with %0d errors", errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout, the core never halted within the time limit");
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/tinker_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tinker_core (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 run,
    input  tinker_pkg::apb_req_t apb,
    output tinker_pkg::apb_rsp_t apb_out,
    output logic                 hlt
);

    logic [tinker_pkg::xlen-1:0]           pc;
    logic [tinker_pkg::ilen-1:0]           instr;
    logic [tinker_pkg::xlen-1:0]           load_data;
    logic [tinker_pkg::xlen-1:0]           rs_val;
    logic [tinker_pkg::xlen-1:0]           rt_val;
    logic [tinker_pkg::xlen-1:0]           rd_val;
    logic [tinker_pkg::reg_addr_width-1:0] rs_addr;
    logic [tinker_pkg::reg_addr_width-1:0] rt_addr;
    logic [tinker_pkg::reg_addr_width-1:0] rd_addr;
    logic                                  stall;
    logic                                  flush;
    logic                                  busy;
    tinker_pkg::decoded_t                  dec;
    tinker_pkg::decoded_t                  dx;
    tinker_pkg::ex_mem_t                   xm;
    tinker_pkg::mem_wb_t                   mw;
    tinker_pkg::fwd_t                      load_hazard;
    tinker_pkg::fwd_t                      fwd_mem;
    tinker_pkg::fwd_t                      fwd_wb;

    assign busy = run && !hlt;

    // load in execute, its data only exists once it reaches writeback
    assign load_hazard = '{write: dx.valid && dx.op == tinker_pkg::op_load,
                           rd: dx.rd, value: '0};
    assign fwd_mem = '{write: xm.valid && xm.reg_write && xm.op != tinker_pkg::op_load,
                       rd: xm.rd, value: xm.result};
    assign fwd_wb  = '{write: mw.valid && mw.reg_write, rd: mw.rd, value: mw.value};

    fetch_unit u_fetch (
        .clk(clk), .reset(reset), .run(run), .instr(instr), .pc(pc),
        .redirect(xm.redirect), .target(xm.target), .load_hazard_rd(load_hazard),
        .stall(stall), .dec(dec), .rs_addr(rs_addr), .rt_addr(rt_addr), .rd_addr(rd_addr)
    );

    register_file u_regs (
        .clk(clk), .reset(reset), .rs_addr(rs_addr), .rt_addr(rt_addr), .rd_addr(rd_addr),
        .lit_sel(dec.lit_sel), .lit(dec.lit), .wb(mw),
        .rs_val(rs_val), .rt_val(rt_val), .rd_val(rd_val)
    );

    execute_unit u_exec (
        .clk(clk), .reset(reset), .dx(dx), .fwd_mem(fwd_mem), .fwd_wb(fwd_wb),
        .flush(flush), .xm(xm)
    );

    unified_memory u_mem (
        .clk(clk), .reset(reset), .busy(busy), .pc(pc), .instr(instr), .xm(xm),
        .load_data(load_data), .apb(apb), .apb_out(apb_out)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dx <= '0;
        end else begin
            dx        <= dec;
            dx.rs_val <= rs_val;
            dx.rt_val <= rt_val;
            dx.rd_val <= rd_val;
            if (flush || stall)
                dx.valid <= 1'b0;   // bubble
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mw <= '0;
        end else begin
            mw.valid     <= xm.valid;
            mw.rd        <= xm.rd;
            mw.reg_write <= xm.reg_write;
            mw.value     <= (xm.op == tinker_pkg::op_load) ? load_data : xm.result;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            hlt <= 1'b0;
        else if (xm.valid && xm.op == tinker_pkg::op_halt)
            hlt <= 1'b1;    // sticky until next reset
    end

endmodule

`default_nettype wire

// ==== source/unified_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module unified_memory (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        busy,
    input  logic [tinker_pkg::xlen-1:0] pc,
    output logic [tinker_pkg::ilen-1:0] instr,
    input  tinker_pkg::ex_mem_t         xm,
    output logic [tinker_pkg::xlen-1:0] load_data,
    input  tinker_pkg::apb_req_t        apb,
    output tinker_pkg::apb_rsp_t        apb_out
);

    logic [7:0]            mem [tinker_pkg::mem_bytes];
    tinker_pkg::mem_addr_t pc_a;
    tinker_pkg::mem_addr_t word_a;
    logic                  apb_wr;
    logic                  core_wr;

    assign pc_a    = pc[tinker_pkg::mem_addr_width-1:0];
    assign word_a  = {apb.paddr[15:2], 2'b00};
    assign apb_wr  = apb.psel && apb.penable && apb.pwrite && !busy;
    assign core_wr = xm.valid && xm.mem_write;

    // all reads combinational, little-endian, wrapping at the top
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            instr[8*i +: 8]          = mem[pc_a + tinker_pkg::mem_addr_t'(i)];
            apb_out.prdata[8*i +: 8] = mem[word_a + tinker_pkg::mem_addr_t'(i)];
        end
        for (int i = 0; i < 8; i++)
            load_data[8*i +: 8] = mem[xm.addr + tinker_pkg::mem_addr_t'(i)];
        apb_out.pready  = 1'b1;
        apb_out.pslverr = apb.psel && busy;    // core owns memory while running
    end

    always_ff @(posedge clk) begin
        if (core_wr) begin
            for (int i = 0; i < 8; i++)
                mem[xm.addr + tinker_pkg::mem_addr_t'(i)] <= xm.wdata[8*i +: 8];
        end
        if (apb_wr) begin
            for (int i = 0; i < 4; i++)
                mem[word_a + tinker_pkg::mem_addr_t'(i)] <= apb.pwdata[8*i +: 8];
        end
    end

    one_writer: assert property (@(posedge clk) disable iff (reset)
        !(apb_wr && core_wr));

endmodule

`default_nettype wire

// ==== source/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  tinker_pkg::decoded_t dx,
    input  tinker_pkg::fwd_t     fwd_mem,
    input  tinker_pkg::fwd_t     fwd_wb,
    output logic                 flush,
    output tinker_pkg::ex_mem_t  xm
);

    logic [tinker_pkg::xlen-1:0] a;    // rs
    logic [tinker_pkg::xlen-1:0] b;    // rt or literal
    logic [tinker_pkg::xlen-1:0] d;    // rd as a source
    logic [tinker_pkg::xlen-1:0] ea;
    tinker_pkg::ex_mem_t         nxt;

    // newer producer wins
    function automatic logic [tinker_pkg::xlen-1:0] pick(
        input logic [tinker_pkg::reg_addr_width-1:0] addr,
        input logic [tinker_pkg::xlen-1:0]           regval,
        input tinker_pkg::fwd_t                      near,
        input tinker_pkg::fwd_t                      far
    );
        if (near.write && near.rd == addr)
            return near.value;
        if (far.write && far.rd == addr)
            return far.value;
        return regval;
    endfunction

    assign flush = xm.redirect;

    always_comb begin
        a   = pick(dx.rs, dx.rs_val, fwd_mem, fwd_wb);
        b   = dx.lit_sel ? dx.rt_val : pick(dx.rt, dx.rt_val, fwd_mem, fwd_wb);
        d   = pick(dx.rd, dx.rd_val, fwd_mem, fwd_wb);
        ea  = '0;
        nxt = '0;
        nxt.op        = dx.op;
        nxt.rd        = dx.rd;
        nxt.reg_write = 1'b1;
        case (dx.op)
            tinker_pkg::op_add:    nxt.result = a + b;
            tinker_pkg::op_addi:   nxt.result = d + b;
            tinker_pkg::op_sub:    nxt.result = a - b;
            tinker_pkg::op_subi:   nxt.result = d - b;
            tinker_pkg::op_mul:    nxt.result = a * b;
            tinker_pkg::op_and:    nxt.result = a & b;
            tinker_pkg::op_or:     nxt.result = a | b;
            tinker_pkg::op_xor:    nxt.result = a ^ b;
            tinker_pkg::op_not:    nxt.result = ~a;
            tinker_pkg::op_shftr:  nxt.result = a >> b;
            tinker_pkg::op_shftri: nxt.result = d >> b;
            tinker_pkg::op_shftl:  nxt.result = a << b;
            tinker_pkg::op_shftli: nxt.result = d << b;
            tinker_pkg::op_mov:    nxt.result = a;
            tinker_pkg::op_movl:
                nxt.result = {d[tinker_pkg::xlen-1:tinker_pkg::lit_width], dx.lit};
            tinker_pkg::op_load: begin
                ea         = a + b;
                nxt.result = ea;    // replaced by load data in memory stage
            end
            tinker_pkg::op_store: begin
                ea            = d + b;
                nxt.reg_write = 1'b0;
                nxt.mem_write = 1'b1;
                nxt.wdata     = a;
            end
            tinker_pkg::op_br: begin
                nxt.reg_write = 1'b0;
                nxt.redirect  = 1'b1;
                nxt.target    = dx.pc + b;
            end
            tinker_pkg::op_brnz: begin
                nxt.reg_write = 1'b0;
                nxt.redirect  = a != '0;
                nxt.target    = d;
            end
            tinker_pkg::op_brgt: begin
                nxt.reg_write = 1'b0;
                nxt.redirect  = $signed(a) > $signed(b);
                nxt.target    = d;
            end
            default: nxt.reg_write = 1'b0;  // halt
        endcase
        nxt.addr  = ea[tinker_pkg::mem_addr_width-1:0];
        nxt.valid = dx.valid && !flush;     // youngest after a taken branch dies here
        if (!nxt.valid) begin
            nxt.reg_write = 1'b0;
            nxt.mem_write = 1'b0;
            nxt.redirect  = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            xm <= '0;
        else
            xm <= nxt;
    end

    no_dual_write: assert property (@(posedge clk) disable iff (reset)
        xm.valid |-> !(xm.mem_write && xm.reg_write));

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [tinker_pkg::reg_addr_width-1:0] rs_addr,
    input  logic [tinker_pkg::reg_addr_width-1:0] rt_addr,
    input  logic [tinker_pkg::reg_addr_width-1:0] rd_addr,
    input  logic                                  lit_sel,
    input  logic [tinker_pkg::lit_width-1:0]      lit,
    input  tinker_pkg::mem_wb_t                   wb,
    output logic [tinker_pkg::xlen-1:0]           rs_val,
    output logic [tinker_pkg::xlen-1:0]           rt_val,
    output logic [tinker_pkg::xlen-1:0]           rd_val
);

    logic [tinker_pkg::xlen-1:0] regs [32];
    logic                        wb_hit;

    assign wb_hit = wb.valid && wb.reg_write;

    // writeback passes straight through to a reader in the same cycle
    always_comb begin
        rs_val = (wb_hit && wb.rd == rs_addr) ? wb.value : regs[rs_addr];
        rt_val = (wb_hit && wb.rd == rt_addr) ? wb.value : regs[rt_addr];
        rd_val = (wb_hit && wb.rd == rd_addr) ? wb.value : regs[rd_addr];
        if (lit_sel)
            rt_val = {{(tinker_pkg::xlen - tinker_pkg::lit_width){lit[11]}}, lit};
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 31; i++)
                regs[i] <= '0;
            regs[31] <= tinker_pkg::reset_sp;
        end else if (wb_hit) begin
            regs[wb.rd] <= wb.value;
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  run,
    input  logic [tinker_pkg::ilen-1:0]           instr,
    output logic [tinker_pkg::xlen-1:0]           pc,
    input  logic                                  redirect,
    input  logic [tinker_pkg::xlen-1:0]           target,
    input  tinker_pkg::fwd_t                      load_hazard_rd,
    output logic                                  stall,
    output tinker_pkg::decoded_t                  dec,
    output logic [tinker_pkg::reg_addr_width-1:0] rs_addr,
    output logic [tinker_pkg::reg_addr_width-1:0] rt_addr,
    output logic [tinker_pkg::reg_addr_width-1:0] rd_addr
);

    logic [tinker_pkg::ilen-1:0] ir;
    logic [tinker_pkg::xlen-1:0] ir_pc;
    logic                        ir_valid;
    logic                        stopped;   // halt decoded, fetch parked
    logic                        lit_sel;
    logic                        hazard;
    logic                        halt_dec;
    logic                        take;
    tinker_pkg::op_t             op;

    assign op      = tinker_pkg::op_t'(ir[31:27]);
    assign rd_addr = ir[26:22];
    assign rs_addr = ir[21:17];
    assign rt_addr = ir[16:12];

    always_comb begin
        case (op)
            tinker_pkg::op_addi, tinker_pkg::op_subi, tinker_pkg::op_shftri,
            tinker_pkg::op_shftli, tinker_pkg::op_movl, tinker_pkg::op_br,
            tinker_pkg::op_load, tinker_pkg::op_store: lit_sel = 1'b1;
            default: lit_sel = 1'b0;
        endcase
    end

    // conservative, any named register may be the load target
    assign hazard = ir_valid && load_hazard_rd.write &&
                    (load_hazard_rd.rd == rs_addr || load_hazard_rd.rd == rd_addr ||
                     (!lit_sel && load_hazard_rd.rd == rt_addr));
    assign stall    = hazard && !redirect;
    assign halt_dec = ir_valid && op == tinker_pkg::op_halt;
    assign take     = run && !stopped && !halt_dec && !stall && !redirect;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc       <= tinker_pkg::reset_pc;
            ir_valid <= 1'b0;
            stopped  <= 1'b0;
        end else if (redirect) begin
            pc       <= target;
            ir_valid <= 1'b0;   // flush decode
            stopped  <= 1'b0;
        end else if (!stall) begin
            if (take)
                pc <= pc + 64'd4;
            ir_valid <= take;
            if (halt_dec)
                stopped <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            ir    <= instr;
            ir_pc <= pc;
        end
    end

    always_comb begin
        dec         = '0;   // register values are filled in by the core
        dec.pc      = ir_pc;
        dec.op      = ir_valid ? op : tinker_pkg::nop;
        dec.rd      = rd_addr;
        dec.rs      = rs_addr;
        dec.rt      = rt_addr;
        dec.lit     = ir[11:0];
        dec.lit_sel = lit_sel;
        dec.valid   = ir_valid;
    end

    redirect_wins: assert property (@(posedge clk) disable iff (reset)
        redirect |=> pc == $past(target));

endmodule

`default_nettype wire

// ==== source/tinker_pkg.sv ====
`default_nettype none

package tinker_pkg;

    localparam int xlen           = 64;
    localparam int ilen           = 32;
    localparam int op_width       = 5;
    localparam int reg_addr_width = 5;
    localparam int lit_width      = 12;
    localparam int mem_bytes      = 65536;
    localparam int mem_addr_width = 16;

    localparam logic [xlen-1:0] reset_pc = 64'h2000;
    localparam logic [xlen-1:0] reset_sp = xlen'(mem_bytes); // stack starts past the top

    typedef logic [mem_addr_width-1:0] mem_addr_t;

    typedef enum logic [op_width-1:0] {
        op_and    = 5'h00,
        op_or     = 5'h01,
        op_xor    = 5'h02,
        op_not    = 5'h03,
        op_shftr  = 5'h04,
        op_shftri = 5'h05,
        op_shftl  = 5'h06,
        op_shftli = 5'h07,
        op_br     = 5'h0a, // pc + L
        op_brnz   = 5'h0b,
        op_brgt   = 5'h0e,
        op_halt   = 5'h0f,
        op_load   = 5'h10,
        op_mov    = 5'h11,
        op_movl   = 5'h12, // low 12 bits of rd from L
        op_store  = 5'h13,
        op_add    = 5'h18,
        op_addi   = 5'h19,
        op_sub    = 5'h1a,
        op_subi   = 5'h1b,
        op_mul    = 5'h1c
    } op_t;

    // the all-zero word, bubbles are told apart by valid
    localparam op_t nop = op_and;

    typedef struct packed {
        logic [xlen-1:0]           pc;
        op_t                       op;
        logic [reg_addr_width-1:0] rd;
        logic [reg_addr_width-1:0] rs;
        logic [reg_addr_width-1:0] rt;
        logic [lit_width-1:0]      lit;
        logic                      lit_sel;  // second operand is L
        logic [xlen-1:0]           rs_val;
        logic [xlen-1:0]           rt_val;
        logic [xlen-1:0]           rd_val;
        logic                      valid;
    } decoded_t;

    typedef struct packed {
        logic                      valid;
        op_t                       op;
        logic [reg_addr_width-1:0] rd;
        logic [xlen-1:0]           result;
        logic                      reg_write;
        logic                      mem_write;
        mem_addr_t                 addr;
        logic [xlen-1:0]           wdata;
        logic                      redirect;
        logic [xlen-1:0]           target;
    } ex_mem_t;

    typedef struct packed {
        logic                      valid;
        logic [reg_addr_width-1:0] rd;
        logic                      reg_write;
        logic [xlen-1:0]           value;
    } mem_wb_t;

    typedef struct packed {
        logic                      write;
        logic [reg_addr_width-1:0] rd;
        logic [xlen-1:0]           value;
    } fwd_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [15:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire
